// ==== aib_adapttxdp_fifo/aib_adapttxdp_fifo_ptr.sv ====
/* Pointer and occupancy control of the transmit FIFO.
   Decides write acceptance, overwrite drop and the full and empty flags. */
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_fifo_ptr
  import txdp_pkg::*;
(
  input  logic         wr_clk,                // Write domain clock
  input  logic         wr_rst_n,              // Sync reset, active low
  input  txdp_cfg_s    cfg,                   // Static configuration
  input  logic         wr_req,                // Upstream write strobe
  input  logic         pop,                   // Head consumed by output FSM
  output fifo_oh_ptr_t wr_ptr,                // One-hot write slot
  output fifo_oh_ptr_t rd_ptr,                // One-hot head slot
  output logic         mem_wr_en,             // Qualified memory write
  output logic         full,                  // Fewer than N slots free
  output logic         empty                  // Nothing stored
);

  fifo_cnt_t    occ_cnt;                      // Stored words
  fifo_cnt_t    occ_cnt_nxt;
  fifo_cnt_t    words_n;                      // Words per write
  fifo_cnt_t    free_cnt;                     // Free slots
  fifo_cnt_t    cnt_add;
  fifo_cnt_t    cnt_sub;
  fifo_oh_ptr_t wr_ptr_nxt;
  fifo_oh_ptr_t rd_ptr_nxt;
  logic         wr_accept;                    // Write goes into memory
  logic         wr_drop;                      // Overwrite of oldest entries

  // Rotate a one-hot ring by one or two slots
  function automatic fifo_oh_ptr_t rotate_oh(input fifo_oh_ptr_t ptr, input logic by_two);
    fifo_oh_ptr_t one_step;
    one_step = {ptr[FIFO_DEPTH-2:0], ptr[FIFO_DEPTH-1]};
    if (by_two) begin
      rotate_oh = {one_step[FIFO_DEPTH-2:0], one_step[FIFO_DEPTH-1]};
    end else begin
      rotate_oh = one_step;
    end
  endfunction

  // **************************************************
  // Flags and write acceptance
  // **************************************************

  assign words_n  = cfg.double_write ? fifo_cnt_t'(2) : fifo_cnt_t'(1);
  assign free_cnt = fifo_cnt_t'(FIFO_DEPTH) - occ_cnt;
  assign full     = (free_cnt < words_n);     // No room for a whole write
  assign empty    = (occ_cnt == '0);

  // Full only blocks when stop_write is set
  assign wr_accept = wr_req && (!full || !cfg.stop_write);
  assign wr_drop   = wr_accept && full;       // Make room by dropping oldest
  assign mem_wr_en = wr_accept;

  // **************************************************
  // Next pointer and count
  // **************************************************

  assign wr_ptr_nxt = wr_accept ? rotate_oh(wr_ptr, cfg.double_write) : wr_ptr;

  // Drop wins over pop, the popped word is already latched downstream
  always_comb begin
    if (wr_drop) begin
      rd_ptr_nxt = rotate_oh(rd_ptr, cfg.double_write);
    end else if (pop) begin
      rd_ptr_nxt = rotate_oh(rd_ptr, 1'b0);
    end else begin
      rd_ptr_nxt = rd_ptr;
    end
  end

  assign cnt_add = wr_accept ? words_n : '0;
  assign cnt_sub = wr_drop ? words_n : (pop ? fifo_cnt_t'(1) : '0);
  assign occ_cnt_nxt = occ_cnt + cnt_add - cnt_sub;

  // **************************************************
  // State registers
  // **************************************************

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_ptr  <= fifo_oh_ptr_t'(1);           // Both rings at entry 0
      rd_ptr  <= fifo_oh_ptr_t'(1);
      occ_cnt <= '0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      rd_ptr  <= rd_ptr_nxt;
      occ_cnt <= occ_cnt_nxt;
    end
  end

endmodule : aib_adapttxdp_fifo_ptr

`default_nettype wire

// ==== aib_adapttxdp_fifo/aib_adapttxdp_fifo_ram.sv ====
/* Storage array of the transmit FIFO, written through a one-hot pointer.
   Takes an already qualified write enable and reads the one-hot head combinationally. */
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_fifo_ram
  import txdp_pkg::*;
#(
  parameter int DWIDTH = DATA_W,              // Word width
  parameter int DEPTH  = FIFO_DEPTH           // Entry count
) (
  input  logic              wr_clk,           // Write domain clock
  input  logic              wr_rst_n,         // Sync reset, active low
  input  logic              wr_en,            // Qualified write strobe
  input  logic              double_write,     // Store second word too
  input  logic [DEPTH-1:0]  wr_ptr,           // One-hot write slot
  input  logic [DWIDTH-1:0] wr_data,          // Word for wr_ptr slot
  input  logic [DWIDTH-1:0] wr_data2,         // Word for the slot after
  input  logic [DEPTH-1:0]  rd_ptr,           // One-hot head slot
  output logic [DWIDTH-1:0] rd_data           // Head word
);

  logic [DWIDTH-1:0] fifo_mem [DEPTH];        // Entry storage
  logic [DEPTH-1:0]  wr_ptr_next;             // Slot following wr_ptr

  // Second slot of a double write, wraps past the top entry
  assign wr_ptr_next = {wr_ptr[DEPTH-2:0], wr_ptr[DEPTH-1]};

  // **************************************************
  // Write port
  // **************************************************

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      for (int m = 0; m < DEPTH; m++) begin
        fifo_mem[m] <= '0;                    // Clear all entries
      end
    end else if (wr_en) begin
      for (int m = 0; m < DEPTH; m++) begin
        if (wr_ptr[m]) begin
          fifo_mem[m] <= wr_data;             // Primary slot
        end else if (double_write && wr_ptr_next[m]) begin
          fifo_mem[m] <= wr_data2;            // Paired slot
        end
      end
    end
  end

  // **************************************************
  // Read port
  // **************************************************

  // AND-OR mux, rd_ptr is one-hot so one term survives
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < DEPTH; i++) begin
      rd_data = rd_data | ({DWIDTH{rd_ptr[i]}} & fifo_mem[i]);
    end
  end

endmodule : aib_adapttxdp_fifo_ram

`default_nettype wire

// ==== aib_adapttxdp_fifo/aib_adapttxdp_fifo_rd_fsm.sv ====
/* Output side of the transmit FIFO. Latches the head word and runs the
   four-phase req/ack handshake, pulsing pop when the word is acknowledged. */
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_fifo_rd_fsm
  import txdp_pkg::*;
(
  input  logic       wr_clk,                  // Write domain clock
  input  logic       wr_rst_n,                // Sync reset, active low
  input  logic       empty,                   // FIFO holds nothing
  input  fifo_data_t head_data,               // Word at rd_ptr
  input  logic       tx_ack,                  // Downstream acknowledge
  output logic       tx_req,                  // Word valid request
  output fifo_data_t tx_data,                 // Held word
  output logic       pop                      // Advance rd_ptr
);

  rd_state_e  rd_state;                       // Current handshake phase
  rd_state_e  rd_state_nxt;
  logic       load_word;                      // Capture head into tx_data

  // **************************************************
  // Next state
  // **************************************************

  always_comb begin
    rd_state_nxt = rd_state;
    load_word    = 1'b0;
    pop          = 1'b0;
    case (rd_state)
      RD_IDLE: begin
        if (!empty) begin
          load_word    = 1'b1;                // Head is valid, take it
          rd_state_nxt = RD_REQ;
        end
      end
      RD_REQ: begin
        if (tx_ack) begin
          pop          = 1'b1;                // Entry released on ack
          rd_state_nxt = RD_RELEASE;
        end
      end
      RD_RELEASE: begin
        // Phase 4, wait for ack to fall before the next word
        if (!tx_ack) begin
          rd_state_nxt = RD_IDLE;
        end
      end
      default: begin
        rd_state_nxt = RD_IDLE;               // Recover from illegal code
      end
    endcase
  end

  // **************************************************
  // State and payload registers
  // **************************************************

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      rd_state <= rd_state_nxt;
    end
  end

  // Payload only moves in IDLE, so it is stable while req is up
  always_ff @(posedge wr_clk) begin
    if (load_word) begin
      tx_data <= head_data;
    end
  end

  assign tx_req = (rd_state == RD_REQ);       // Registered through state

endmodule : aib_adapttxdp_fifo_rd_fsm

`default_nettype wire

// ==== common/txdp_pkg.sv ====
/* Shared sizes, word types and control structs for the transmit datapath FIFO.
   Imported by every RTL block of the adapter transmit path. */
`default_nettype none

package txdp_pkg;

  // **************************************************
  // FIFO sizing
  // **************************************************

  localparam int FIFO_DEPTH = 16;             // Entries, kept even for double write
  localparam int DATA_W     = 40;             // Datapath word width
  localparam int CNT_W      = 5;              // Occupancy 0..16

  // **************************************************
  // Vector types
  // **************************************************

  typedef logic [DATA_W-1:0]     fifo_data_t;   // One datapath word
  typedef logic [FIFO_DEPTH-1:0] fifo_oh_ptr_t; // One-hot entry pointer
  typedef logic [CNT_W-1:0]      fifo_cnt_t;    // Occupancy count

  // **************************************************
  // Control and write bundles
  // **************************************************

  // Static configuration, only changed while drained
  typedef struct packed {
    logic double_write;                       // Two words per write
    logic stop_write;                         // Refuse writes when full
  } txdp_cfg_s;

  // Upstream write request
  typedef struct packed {
    logic       en;                           // Write strobe
    fifo_data_t data;                         // First word
    fifo_data_t data2;                        // Second word, double write only
  } txdp_wr_s;

  // Output handshake states
  typedef enum logic [1:0] {
    RD_IDLE    = 2'd0,                        // Waiting for a stored word
    RD_REQ     = 2'd1,                        // Request up, waiting for ack
    RD_RELEASE = 2'd2                         // Request down, waiting for ack low
  } rd_state_e;

endpackage : txdp_pkg

`default_nettype wire

// ==== compile.f ====
common/txdp_pkg.sv
aib_adapttxdp_fifo/aib_adapttxdp_fifo_ram.sv
aib_adapttxdp_fifo/aib_adapttxdp_fifo_ptr.sv
aib_adapttxdp_fifo/aib_adapttxdp_fifo_rd_fsm.sv
rtl/aib_adapttxdp_top.sv
verif/tb_aib_adapttxdp.sv

// ==== rtl/aib_adapttxdp_top.sv ====
/* Transmit datapath FIFO of the die-to-die adapter. Upstream writes one or two
   words per strobe, words leave one at a time over a four-phase req/ack. */
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_top
  import txdp_pkg::*;
(
  input  logic       wr_clk,                  // Single clock domain
  input  logic       wr_rst_n,                // Sync reset, active low
  input  txdp_cfg_s  cfg,                     // Write mode configuration
  input  txdp_wr_s   wr,                      // Upstream write bundle
  output logic       full,                    // Back to upstream
  output logic       tx_req,                  // Downstream request
  output fifo_data_t tx_data,                 // Downstream word
  input  logic       tx_ack                   // Downstream acknowledge
);

  fifo_oh_ptr_t wr_ptr;                       // One-hot write slot
  fifo_oh_ptr_t rd_ptr;                       // One-hot head slot
  logic         mem_wr_en;                    // Accepted write
  logic         empty;
  logic         pop;                          // Head consumed
  fifo_data_t   head_data;                    // Word at rd_ptr

  // **************************************************
  // Pointer and flag control
  // **************************************************

  aib_adapttxdp_fifo_ptr u_fifo_ptr (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .cfg       (cfg),
    .wr_req    (wr.en),
    .pop       (pop),
    .wr_ptr    (wr_ptr),
    .rd_ptr    (rd_ptr),
    .mem_wr_en (mem_wr_en),
    .full      (full),
    .empty     (empty)
  );

  // **************************************************
  // Storage
  // **************************************************

  aib_adapttxdp_fifo_ram #(
    .DWIDTH (DATA_W),
    .DEPTH  (FIFO_DEPTH)
  ) u_fifo_ram (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (mem_wr_en),
    .double_write (cfg.double_write),
    .wr_ptr       (wr_ptr),
    .wr_data      (wr.data),
    .wr_data2     (wr.data2),
    .rd_ptr       (rd_ptr),
    .rd_data      (head_data)
  );

  // Output handshake
  aib_adapttxdp_fifo_rd_fsm u_rd_fsm (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .empty     (empty),
    .head_data (head_data),
    .tx_ack    (tx_ack),
    .tx_req    (tx_req),
    .tx_data   (tx_data),
    .pop       (pop)
  );

endmodule : aib_adapttxdp_top

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the transmit FIFO testbench with Verilator.
# The log is searched for the fail message to decide the result.
set -e
cd "$(dirname "$0")"

TOP=tb_aib_adapttxdp
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
  --top-module "$TOP" -f compile.f

./obj_dir/V"$TOP" 2>&1 | tee "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== verif/tb_aib_adapttxdp.sv ====
/* Self-checking testbench for the transmit datapath FIFO. Drives writes, answers
   the req/ack handshake with random delays and checks every word against a queue model. */
`timescale 1ns/1ps
`default_nettype none

module tb_aib_adapttxdp
  import txdp_pkg::*;
();

  localparam int          CLK_HALF      = 20;            // 40 ns period
  localparam int          RST_CYCLES    = 8;
  localparam int          TIMEOUT_LIMIT = 20000;         // Tests need about 5k cycles worst case
  localparam int unsigned SEED          = 32'h9ff2f732;

  logic       wr_clk;
  logic       wr_rst_n;
  txdp_cfg_s  cfg;
  txdp_wr_s   wr;
  logic       full;
  logic       tx_req;
  fifo_data_t tx_data;
  logic       tx_ack;

  fifo_data_t model_q[$];                                // Expected FIFO contents, oldest first
  fifo_data_t head_snap;                                 // Model head before the last edge
  fifo_data_t held_data;                                 // Word shown at the last req rise
  logic       exp_full;                                  // Model full after the last edge
  logic       prev_req;
  logic       ack_stall;                                 // Holds the responder off
  int         words_out  = 0;                            // Words seen at tx_req rises
  int         cycle_cnt  = 0;
  int         fail_cnt   = 0;
  string      test_name;

  aib_adapttxdp_top uut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .cfg      (cfg),
    .wr       (wr),
    .full     (full),
    .tx_req   (tx_req),
    .tx_data  (tx_data),
    .tx_ack   (tx_ack)
  );

  initial begin
    wr_clk = 1'b0;
    forever #CLK_HALF wr_clk = ~wr_clk;
  end

  // **************************************************
  // Check, reference model and random data
  // **************************************************

  task automatic check_value(input string name, input fifo_data_t expected,
                             input fifo_data_t actual);
    if (expected !== actual) begin
      fail_cnt++;
      $display("[FAIL] %s %s expected %h actual %h", test_name, name, expected, actual);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // One clock of the FIFO rules, returns the number of dropped words
  function automatic int model_step(input txdp_cfg_s c, input txdp_wr_s w,
                                    input logic popped, output logic full_after);
    int   n;
    int   dropped;
    logic full_now;
    n        = c.double_write ? 2 : 1;                   // Words per write
    dropped  = 0;
    full_now = (FIFO_DEPTH - model_q.size()) < n;
    if (w.en && (!full_now || !c.stop_write)) begin
      if (full_now) begin
        repeat (n) begin
          void'(model_q.pop_front());                    // Oldest go first
          dropped++;
        end
      end else if (popped) begin
        void'(model_q.pop_front());
      end
      model_q.push_back(w.data);
      if (n == 2) begin
        model_q.push_back(w.data2);                      // Pair stays in order
      end
    end else if (popped) begin
      void'(model_q.pop_front());
    end
    full_after = (FIFO_DEPTH - model_q.size()) < n;
    return dropped;
  endfunction

  function automatic fifo_data_t rand_word();
    logic [63:0] raw;
    raw = {$urandom(), $urandom()};
    return raw[DATA_W-1:0];
  endfunction

  // Model follows the inputs and pop as the DUT samples them
  always @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      model_q.delete();
      exp_full = 1'b0;
    end else begin
      if (model_q.size() > 0) begin
        head_snap = model_q[0];                          // Word the FSM would latch
      end
      void'(model_step(cfg, wr, tx_req && tx_ack, exp_full));
    end
  end

  // Compare at the falling edge, all DUT outputs settled
  always @(negedge wr_clk) begin
    if (wr_rst_n) begin
      check_value("full", fifo_data_t'(exp_full), fifo_data_t'(full));
      if (tx_req && !prev_req) begin
        check_value("ack_low_at_req", '0, fifo_data_t'(tx_ack)); // Four-phase rule
        check_value("tx_data", head_snap, tx_data);
        held_data = tx_data;
        words_out++;
      end else if (tx_req) begin
        check_value("tx_data_stable", held_data, tx_data);
      end
      prev_req = tx_req;
    end else begin
      prev_req = 1'b0;
    end
  end

  // **************************************************
  // Downstream responder and timeout
  // **************************************************

  initial begin
    int dly;
    forever begin
      @(posedge wr_clk);
      if (tx_req && !tx_ack && !ack_stall) begin
        dly = $urandom_range(5, 0);
        repeat (dly) @(posedge wr_clk);
        tx_ack <= 1'b1;
        @(posedge wr_clk);
        while (tx_req) @(posedge wr_clk);                // Wait for req to drop
        dly = $urandom_range(5, 0);
        repeat (dly) @(posedge wr_clk);
        tx_ack <= 1'b0;
      end
    end
  end

  always @(posedge wr_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_LIMIT);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  // **************************************************
  // Stimulus tasks
  // **************************************************

  // Single strobe, only once full is low
  task automatic write_when_room(input fifo_data_t d1, input fifo_data_t d2);
    @(posedge wr_clk);
    while (full) @(posedge wr_clk);
    wr <= {1'b1, d1, d2};
    @(posedge wr_clk);
    wr.en <= 1'b0;
  endtask

  // Back-to-back strobes regardless of full
  task automatic burst_write(input int count);
    repeat (count) begin
      @(posedge wr_clk);
      wr <= {1'b1, rand_word(), rand_word()};
    end
    @(posedge wr_clk);
    wr.en <= 1'b0;
  endtask

  task automatic drain_fifo();
    @(negedge wr_clk);
    while (model_q.size() != 0 || tx_req || tx_ack) @(negedge wr_clk);
    repeat (2) @(posedge wr_clk);
  endtask

  // **************************************************
  // Test sequence
  // **************************************************

  initial begin
    int          out_start;
    wr_rst_n  = 1'b0;
    cfg       = '0;
    wr        = '0;
    tx_ack    = 1'b0;
    ack_stall = 1'b0;
    prev_req  = 1'b0;
    exp_full  = 1'b0;
    head_snap = '0;
    held_data = '0;
    void'($urandom(SEED));
    test_name = "reset";
    repeat (RST_CYCLES) @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    repeat (10) begin
      @(negedge wr_clk);
      check_value("tx_req_idle", '0, fifo_data_t'(tx_req)); // Nothing to send
    end

    test_name = "single_write";
    @(posedge wr_clk);
    cfg <= '{double_write: 1'b0, stop_write: 1'b1};
    out_start = words_out;
    repeat (200) begin
      repeat ($urandom_range(3, 0)) @(posedge wr_clk);
      write_when_room(rand_word(), '0);
    end
    drain_fifo();
    check_value("word_count", fifo_data_t'(200), fifo_data_t'(words_out - out_start));

    test_name = "double_write";
    cfg <= '{double_write: 1'b1, stop_write: 1'b1};
    out_start = words_out;
    repeat (40) begin
      repeat ($urandom_range(3, 0)) @(posedge wr_clk);
      write_when_room(rand_word(), rand_word());
    end
    drain_fifo();
    ack_stall <= 1'b1;                                   // Fill to the top with output held
    repeat (8) write_when_room(rand_word(), rand_word());
    @(negedge wr_clk);
    check_value("full_at_depth", fifo_data_t'(1), fifo_data_t'(full));
    ack_stall <= 1'b0;
    drain_fifo();
    check_value("word_count", fifo_data_t'(96), fifo_data_t'(words_out - out_start));

    test_name = "stop_write";
    cfg <= '{double_write: 1'b0, stop_write: 1'b1};
    ack_stall <= 1'b1;
    out_start  = words_out;
    burst_write(24);                                     // 8 beyond depth, refused
    @(negedge wr_clk);
    check_value("full_held", fifo_data_t'(1), fifo_data_t'(full));
    ack_stall <= 1'b0;
    drain_fifo();
    check_value("word_count", fifo_data_t'(16), fifo_data_t'(words_out - out_start));

    test_name = "overwrite";
    cfg <= '{double_write: 1'b0, stop_write: 1'b0};
    ack_stall <= 1'b1;
    out_start  = words_out;
    burst_write(24);
    @(negedge wr_clk);
    check_value("full_flag", fifo_data_t'(1), fifo_data_t'(full));
    ack_stall <= 1'b0;
    drain_fifo();
    // Latched first word plus the 15 newest left after its pop
    check_value("word_count", fifo_data_t'(16), fifo_data_t'(words_out - out_start));

    repeat (4) @(posedge wr_clk);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_aib_adapttxdp

`default_nettype wire
